// ==== src/fpdiv_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the fp32 srt divider
// widths, bias, iteration count, latency
// operand, flag, stage record and digit types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fpdiv_pkg;

    localparam int MANT_W    = 24;   // hidden bit + 23 fraction bits
    localparam int QUOT_W    = 26;   // mantissa + guard + round
    localparam int SRT_ITERS = 13;   // two quotient bits per step
    localparam int EXP_BIAS  = 127;
    localparam int REM_W     = 28;   // sign, 3 int bits, 24 frac bits
    localparam int LATENCY   = 16;   // accept edge to out_valid edge

    // ieee 754 binary32 layout
    typedef struct packed {
        logic              sign;
        logic [7:0]        exp;
        logic [MANT_W-2:0] frac;
    } fp32_t;

    // subnormals fold into CLS_ZERO
    typedef enum logic [1:0] {
        CLS_NORMAL = 2'd0,
        CLS_ZERO   = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } fp_class_e;

    typedef struct packed {
        logic invalid;
        logic div_by_zero;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    typedef logic signed [2:0] qdigit_t;   // -2 .. +2

    // stage 1 -> stage 2
    typedef struct packed {
        logic              sign;
        logic signed [9:0] exp;        // ea - eb + bias
        logic [MANT_W-1:0] dvd_man;
        logic [MANT_W-1:0] dvs_man;
        fp_class_e         res_cls;
        fp_flags_t         flags;
    } div_op_t;

    // stage 2 -> stage 3
    typedef struct packed {
        logic              sign;
        logic signed [9:0] exp;
        logic [QUOT_W-1:0] quot;       // msb has weight 2^0
        logic              sticky;
        fp_class_e         res_cls;
        fp_flags_t         flags;
    } srt_res_t;

endpackage

// ==== src/fp_unpack.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fp32 divider stage 1
// operand split, classification, result class
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fp_unpack (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic               busy,
    input  fpdiv_pkg::fp32_t   dividend,
    input  fpdiv_pkg::fp32_t   divisor,
    output logic               op_valid,
    output fpdiv_pkg::div_op_t op
);

    logic                 accept;
    logic                 sub_in;   // some operand is subnormal
    fpdiv_pkg::fp_class_e cls_a;
    fpdiv_pkg::fp_class_e cls_b;
    fpdiv_pkg::div_op_t   op_nxt;

    function automatic fpdiv_pkg::fp_class_e classify(input fpdiv_pkg::fp32_t v);
        if (v.exp == 8'hff && v.frac == '0) begin
            return fpdiv_pkg::CLS_INF;
        end else if (v.exp == 8'hff) begin
            return fpdiv_pkg::CLS_NAN;
        end else if (v.exp == 8'h00) begin
            return fpdiv_pkg::CLS_ZERO;   // zero or flushed subnormal
        end
        return fpdiv_pkg::CLS_NORMAL;
    endfunction

    assign accept = in_valid & ~busy;   // strobe while busy is dropped
    assign cls_a  = classify(dividend);
    assign cls_b  = classify(divisor);
    assign sub_in = (dividend.exp == 8'h00 && dividend.frac != '0) ||
                    (divisor.exp == 8'h00 && divisor.frac != '0);

    always_comb begin
        op_nxt.sign    = dividend.sign ^ divisor.sign;
        op_nxt.exp     = $signed({2'b00, dividend.exp}) - $signed({2'b00, divisor.exp})
                         + 10'(fpdiv_pkg::EXP_BIAS);
        op_nxt.dvd_man = {1'b1, dividend.frac};   // hidden bit back
        op_nxt.dvs_man = {1'b1, divisor.frac};
        op_nxt.res_cls = fpdiv_pkg::CLS_NORMAL;
        op_nxt.flags   = '0;
        op_nxt.flags.underflow = sub_in;          // flush to zero is reported
        // nan first, then x/0, then inf and zero results
        if (cls_a == fpdiv_pkg::CLS_NAN || cls_b == fpdiv_pkg::CLS_NAN ||
            (cls_a == fpdiv_pkg::CLS_ZERO && cls_b == fpdiv_pkg::CLS_ZERO) ||
            (cls_a == fpdiv_pkg::CLS_INF && cls_b == fpdiv_pkg::CLS_INF)) begin
            op_nxt.res_cls       = fpdiv_pkg::CLS_NAN;
            op_nxt.flags.invalid = 1'b1;
        end else if (cls_b == fpdiv_pkg::CLS_ZERO) begin
            op_nxt.res_cls           = fpdiv_pkg::CLS_INF;
            op_nxt.flags.div_by_zero = 1'b1;
        end else if (cls_a == fpdiv_pkg::CLS_INF) begin
            op_nxt.res_cls = fpdiv_pkg::CLS_INF;   // inf / finite
        end else if (cls_a == fpdiv_pkg::CLS_ZERO || cls_b == fpdiv_pkg::CLS_INF) begin
            op_nxt.res_cls = fpdiv_pkg::CLS_ZERO;  // 0/x or finite/inf
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= accept;   // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op <= op_nxt;
        end
    end

endmodule

// ==== src/srt_quo_sel.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// radix-4 quotient digit selection table
// digit set -2..2, remainder kept within 2d/3
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module srt_quo_sel (
    input  logic [6:0]         rem_est,   // 4w, sign + 2 int + 4 frac at d in [1/2,1)
    input  logic [2:0]         dvs_idx,   // divisor bits after the leading one
    output fpdiv_pkg::qdigit_t digit
);

    logic signed [6:0] y;
    logic [27:0]       thr;      // m2, m1, m0, m-1 packed, units of 1/16
    logic signed [6:0] m_p2;
    logic signed [6:0] m_p1;
    logic signed [6:0] m_z0;
    logic signed [6:0] m_n1;

    assign y = $signed(rem_est);

    // step boundaries per divisor interval [8+i, 9+i)/16
    always_comb begin
        case (dvs_idx)
            3'd0:    thr = {7'd12, 7'd4, -7'd4, -7'd13};
            3'd1:    thr = {7'd14, 7'd4, -7'd6, -7'd15};
            3'd2:    thr = {7'd15, 7'd4, -7'd6, -7'd16};
            3'd3:    thr = {7'd16, 7'd4, -7'd6, -7'd18};
            3'd4:    thr = {7'd18, 7'd6, -7'd8, -7'd20};
            3'd5:    thr = {7'd20, 7'd6, -7'd8, -7'd20};
            3'd6:    thr = {7'd20, 7'd8, -7'd8, -7'd22};
            default: thr = {7'd24, 7'd8, -7'd8, -7'd24};
        endcase
    end

    assign m_p2 = $signed(thr[27:21]);
    assign m_p1 = $signed(thr[20:14]);
    assign m_z0 = $signed(thr[13:7]);
    assign m_n1 = $signed(thr[6:0]);

    always_comb begin
        if (y >= m_p2) begin
            digit = 3'sd2;
        end else if (y >= m_p1) begin
            digit = 3'sd1;
        end else if (y >= m_z0) begin
            digit = 3'sd0;
        end else if (y >= m_n1) begin
            digit = -3'sd1;
        end else begin
            digit = -3'sd2;   // deep negative remainder
        end
    end

endmodule

// ==== src/srt4_divider.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fp32 divider stage 2
// radix-4 srt mantissa recurrence, 13 steps
// on-the-fly quotient conversion, sticky, busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module srt4_divider (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid,
    input  fpdiv_pkg::div_op_t  op,
    output logic                busy,
    output logic                res_valid,
    output fpdiv_pkg::srt_res_t res
);

    logic                           running;    // recurrence active
    logic                           finish;     // last step done, pack next edge
    logic [3:0]                     step_cnt;
    fpdiv_pkg::div_op_t             hold;       // accepted operation
    logic [fpdiv_pkg::REM_W-1:0]    rem;        // partial remainder w, 24 frac bits
    logic [fpdiv_pkg::REM_W-1:0]    rem_init;
    logic [fpdiv_pkg::REM_W-1:0]    rem_x4;
    logic [fpdiv_pkg::REM_W-1:0]    rem_nxt;
    logic [fpdiv_pkg::REM_W-1:0]    dvs_fx;
    logic [fpdiv_pkg::REM_W-1:0]    dmul;       // |digit| * d
    logic [fpdiv_pkg::REM_W-1:0]    dvd_in;
    logic [fpdiv_pkg::REM_W-1:0]    dvs_in;
    logic [fpdiv_pkg::QUOT_W-1:0]   q_reg;      // Q
    logic [fpdiv_pkg::QUOT_W-1:0]   qm_reg;     // Q - 1 ulp
    logic [fpdiv_pkg::QUOT_W-1:0]   q_src;
    logic [fpdiv_pkg::QUOT_W-1:0]   qm_src;
    fpdiv_pkg::qdigit_t             digit;
    fpdiv_pkg::qdigit_t             digit_m1;

    // mantissas in [1,2) scaled to 24 frac bits, x/2 lands on dvd_man itself
    assign dvd_in = {{(fpdiv_pkg::REM_W-fpdiv_pkg::MANT_W){1'b0}}, op.dvd_man};
    assign dvs_in = {{(fpdiv_pkg::REM_W-fpdiv_pkg::MANT_W-1){1'b0}}, op.dvs_man, 1'b0};
    // x >= d starts from x/2 - d with implied Q = 1, else from x/2
    assign rem_init = (op.dvd_man >= op.dvs_man) ? dvd_in - dvs_in : dvd_in;

    assign dvs_fx = {{(fpdiv_pkg::REM_W-fpdiv_pkg::MANT_W-1){1'b0}}, hold.dvs_man, 1'b0};
    assign rem_x4 = {rem[fpdiv_pkg::REM_W-3:0], 2'b00};

    srt_quo_sel u_sel (
        .rem_est (rem_x4[fpdiv_pkg::REM_W-1 -: 7]),
        .dvs_idx (hold.dvs_man[fpdiv_pkg::MANT_W-2 -: 3]),
        .digit   (digit)
    );

    always_comb begin
        case (digit)
            3'sd2, -3'sd2: dmul = {dvs_fx[fpdiv_pkg::REM_W-2:0], 1'b0};
            3'sd0:         dmul = '0;
            default:       dmul = dvs_fx;
        endcase
    end

    assign rem_nxt  = digit[2] ? rem_x4 + dmul : rem_x4 - dmul;   // w' = 4w - q*d
    assign digit_m1 = digit - 3'sd1;
    // negative digit borrows from Q-1, positive one feeds Q-1 from Q
    assign q_src    = digit[2] ? qm_reg : q_reg;
    assign qm_src   = (digit > 0) ? q_reg : qm_reg;
    assign busy     = op_valid | running;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            running   <= 1'b0;
            finish    <= 1'b0;
            step_cnt  <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= finish;
            finish    <= 1'b0;
            if (op_valid) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 4'd1;
                if (step_cnt == 4'(fpdiv_pkg::SRT_ITERS - 1)) begin
                    running <= 1'b0;   // specials run the full count too
                    finish  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            hold   <= op;
            rem    <= rem_init;
            q_reg  <= '0;   // implied leading 1 wraps out after 26 shifts
            qm_reg <= '0;
        end else if (running) begin
            rem    <= rem_nxt;
            q_reg  <= {q_src[fpdiv_pkg::QUOT_W-3:0], digit[1:0]};
            qm_reg <= {qm_src[fpdiv_pkg::QUOT_W-3:0], digit_m1[1:0]};
        end
        if (finish) begin
            res.sign    <= hold.sign;
            res.exp     <= hold.exp;
            res.quot    <= rem[fpdiv_pkg::REM_W-1] ? qm_reg : q_reg;   // floor fix
            res.sticky  <= |rem;
            res.res_cls <= hold.res_cls;
            res.flags   <= hold.flags;
        end
    end

endmodule

// ==== src/fp_round_pack.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fp32 divider stage 3
// normalize, round nearest even, range, specials
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fp_round_pack (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 res_valid,
    input  fpdiv_pkg::srt_res_t  res,
    output logic                 out_valid,
    output fpdiv_pkg::fp32_t     quotient,
    output fpdiv_pkg::fp_flags_t flags
);

    logic [fpdiv_pkg::MANT_W-1:0] man;
    logic [fpdiv_pkg::MANT_W-1:0] man_rnd;
    logic                         guard_b;
    logic                         round_b;
    logic                         round_up;
    logic                         carry;
    logic                         inexact;
    logic signed [9:0]            exp_n;
    logic signed [9:0]            exp_r;
    fpdiv_pkg::fp32_t             q_nxt;
    fpdiv_pkg::fp_flags_t         f_nxt;

    always_comb begin
        if (res.quot[fpdiv_pkg::QUOT_W-1]) begin
            man     = res.quot[fpdiv_pkg::QUOT_W-1:2];
            guard_b = res.quot[1];
            round_b = res.quot[0];
            exp_n   = res.exp;
        end else begin
            man     = res.quot[fpdiv_pkg::QUOT_W-2:1];   // below one, shift up
            guard_b = res.quot[0];
            round_b = 1'b0;
            exp_n   = res.exp - 10'sd1;
        end
    end

    assign round_up = guard_b & (round_b | res.sticky | man[0]);   // ties go to even
    assign inexact  = guard_b | round_b | res.sticky;
    assign {carry, man_rnd} = {1'b0, man} + {{fpdiv_pkg::MANT_W{1'b0}}, round_up};
    assign exp_r    = carry ? exp_n + 10'sd1 : exp_n;   // all-ones mantissa rolled over

    always_comb begin
        q_nxt      = '0;
        q_nxt.sign = res.sign;
        f_nxt      = res.flags;
        case (res.res_cls)
            fpdiv_pkg::CLS_NAN: begin
                q_nxt = 32'h7fc0_0000;   // canonical quiet nan
            end
            fpdiv_pkg::CLS_INF: begin
                q_nxt.exp = 8'hff;
            end
            fpdiv_pkg::CLS_ZERO: begin
                q_nxt.exp = 8'h00;       // signed zero
            end
            default: begin
                f_nxt.inexact = inexact;
                if (exp_r >= 10'sd255) begin
                    q_nxt.exp      = 8'hff;
                    f_nxt.overflow = 1'b1;
                    f_nxt.inexact  = 1'b1;
                end else if (exp_r <= 10'sd0) begin
                    f_nxt.underflow = 1'b1;   // flush, no subnormal output
                    f_nxt.inexact   = 1'b1;
                end else begin
                    q_nxt.exp  = exp_r[7:0];
                    q_nxt.frac = man_rnd[fpdiv_pkg::MANT_W-2:0];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
            quotient  <= '0;
            flags     <= '0;
        end else begin
            out_valid <= res_valid;
            if (res_valid) begin
                quotient <= q_nxt;   // held until the next result
                flags    <= f_nxt;
            end
        end
    end

endmodule

// ==== src/fp_divider.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fp32 radix-4 srt divider top level
// unpack -> srt recurrence -> round and pack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fp_divider (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  fpdiv_pkg::fp32_t     dividend,
    input  fpdiv_pkg::fp32_t     divisor,
    output logic                 busy,
    output logic                 out_valid,
    output fpdiv_pkg::fp32_t     quotient,
    output fpdiv_pkg::fp_flags_t flags
);

    logic                op_valid;
    fpdiv_pkg::div_op_t  op;
    logic                res_valid;
    fpdiv_pkg::srt_res_t res;

    fp_unpack u_unpack (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .busy     (busy),       // blocks a second accept
        .dividend (dividend),
        .divisor  (divisor),
        .op_valid (op_valid),
        .op       (op)
    );

    srt4_divider u_srt (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op        (op),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res)
    );

    fp_round_pack u_pack (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res       (res),
        .out_valid (out_valid),
        .quotient  (quotient),
        .flags     (flags)
    );

endmodule

// ==== bench/fp_divider_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound checks on the fp32 divider top level
// result pulse width, fixed latency, no orphan
// result, output values while in reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fp_divider_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 in_valid,
    input logic                 busy,
    input logic                 out_valid,
    input fpdiv_pkg::fp32_t     quotient,
    input fpdiv_pkg::fp_flags_t flags
);

    logic accept;
    logic rst_held = 1'b0;   // one edge already taken in reset

    assign accept = in_valid & ~busy;   // same rule as the unpack stage

    always @(posedge clk) begin
        rst_held <= ~rst;
    end

    // registered at LATENCY, seen by the sampler one edge later
    a_latency: assert property (@(posedge clk) disable iff (!rst)
        accept |-> ##(fpdiv_pkg::LATENCY + 1) out_valid)
        else $error("no out_valid at the fixed latency after an accepted operation");

    a_pulse: assert property (@(posedge clk) disable iff (!rst)
        out_valid |=> !out_valid)
        else $error("out_valid stayed high for more than one cycle");

    a_orphan: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> $past(accept, fpdiv_pkg::LATENCY + 1))
        else $error("out_valid without an accepted operation before it");

    a_reset: assert property (@(posedge clk)
        (!rst && rst_held) |-> (!busy && !out_valid && quotient == '0 && flags == '0))
        else $error("outputs not cleared while reset is held");

endmodule

// ==== bench/tb_fp_divider.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the fp32 srt divider
// vector file reader, stimulus, scoreboard queue
// quotient, flag and busy checks, closing report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_fp_divider;

    typedef struct packed {
        fpdiv_pkg::fp32_t     q;
        fpdiv_pkg::fp_flags_t f;
        int                   due;   // sampling edge where out_valid must show
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    fpdiv_pkg::fp32_t     dividend;
    fpdiv_pkg::fp32_t     divisor;
    logic                 busy;
    logic                 out_valid;
    fpdiv_pkg::fp32_t     quotient;
    fpdiv_pkg::fp_flags_t flags;

    fpdiv_pkg::fp32_t     pend_q;      // expectation travelling with in_valid
    fpdiv_pkg::fp_flags_t pend_f;
    expect_t              exp_q[$];    // accepted operations only
    int                   cyc;         // sampling edge count after reset
    int                   last_acc;
    logic                 have_acc;
    logic                 exp_busy;
    int                   value_errs;
    int                   timing_errs;
    int                   run_errs;    // timeouts, file trouble
    int                   n_vec;
    int                   n_acc;
    int                   n_res;

    fp_divider dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .out_valid (out_valid),
        .quotient  (quotient),
        .flags     (flags)
    );

    bind fp_divider fp_divider_sva u_sva (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .busy      (busy),
        .out_valid (out_valid),
        .quotient  (quotient),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    task automatic compare_quotient(input fpdiv_pkg::fp32_t exp_v,
                                    input fpdiv_pkg::fp32_t act_v);
        if (act_v !== exp_v) begin
            $display("FAIL t=%0t quotient expected %h got %h", $time, exp_v, act_v);
            value_errs++;
        end
    endtask

    task automatic compare_flags(input fpdiv_pkg::fp_flags_t exp_v,
                                 input fpdiv_pkg::fp_flags_t act_v);
        if (act_v !== exp_v) begin
            $display("FAIL t=%0t flags expected %b got %b", $time, exp_v, act_v);
            value_errs++;
        end
    endtask

    task automatic compare_level(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp_v, act_v);
            timing_errs++;
        end
    endtask

    // busy seen at sampling edges a+1 .. a+LATENCY-2 after acceptance a
    always @(posedge clk) begin : monitor
        expect_t head;
        if (rst) begin
            cyc      = cyc + 1;
            exp_busy = have_acc && (cyc > last_acc) &&
                       (cyc < last_acc + fpdiv_pkg::LATENCY - 1);
            compare_level("busy", exp_busy, busy);
            if (in_valid && !exp_busy) begin   // accepted, else dropped silently
                exp_q.push_back({pend_q, pend_f, cyc + fpdiv_pkg::LATENCY + 1});
                have_acc = 1'b1;
                last_acc = cyc;
                n_acc++;
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid at t=%0t with no accepted operation waiting", $time);
                    timing_errs++;
                end else begin
                    head = exp_q.pop_front();
                    if (head.due != cyc) begin
                        $display("result at t=%0t came on edge %0d instead of edge %0d",
                                 $time, cyc, head.due);
                        timing_errs++;
                    end
                    compare_quotient(head.q, quotient);
                    compare_flags(head.f, flags);
                    n_res++;
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
                $display("no out_valid by t=%0t for an accepted operation", $time);
                timing_errs++;
                void'(exp_q.pop_front());
            end
        end
    end

    task automatic wait_idle(input int limit, output bit ok);
        int i;
        ok = 1'b0;
        for (i = 0; i < limit && !ok; i++) begin
            @(posedge clk);
            if (!busy) ok = 1'b1;
        end
        if (!ok) begin
            $display("timeout at t=%0t, busy stayed high for %0d cycles", $time, limit);
            run_errs++;
        end
    endtask

    // one-cycle strobe, called right at a rising edge
    task automatic issue_vector(input fpdiv_pkg::fp32_t a,
                                input fpdiv_pkg::fp32_t b,
                                input fpdiv_pkg::fp32_t q,
                                input fpdiv_pkg::fp_flags_t f);
        in_valid <= 1'b1;
        dividend <= a;
        divisor  <= b;
        pend_q   <= q;
        pend_f   <= f;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drain_results(input int limit);
        int i;
        bit done;
        done = 1'b0;
        for (i = 0; i < limit && !done; i++) begin
            @(negedge clk);   // away from the monitor's edge
            if (exp_q.size() == 0) done = 1'b1;
        end
        if (!done) begin
            $display("timeout at t=%0t, %0d results never arrived", $time, exp_q.size());
            run_errs++;
        end
        repeat (fpdiv_pkg::LATENCY + 2) @(negedge clk);   // room for a stray pulse
    endtask

    initial begin : stimulus
        int          fd;
        int          n;
        int          gap;
        int          n_line;
        string       line;
        logic [31:0] a_raw;
        logic [31:0] b_raw;
        logic [31:0] q_raw;
        logic [4:0]  f_raw;
        bit          ok;
        bit          stop;
        rst         = 1'b0;
        in_valid    = 1'b0;
        dividend    = '0;
        divisor     = '0;
        pend_q      = '0;
        pend_f      = '0;
        cyc         = 0;
        last_acc    = 0;
        have_acc    = 1'b0;
        exp_busy    = 1'b0;
        value_errs  = 0;
        timing_errs = 0;
        run_errs    = 0;
        n_vec       = 0;
        n_acc       = 0;
        n_res       = 0;
        stop        = 1'b0;
        n_line      = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        fd = $fopen("bench/fpdiv_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file bench/fpdiv_tests.txt");
            run_errs++;
        end else begin
            while (!$feof(fd) && !stop && n_line < 1000) begin
                n_line++;
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%h %h %h %h %d", a_raw, b_raw, q_raw, f_raw, gap);
                    if (n == 5) begin   // comment and blank lines fall through
                        if (gap > 0) begin
                            wait_idle(64, ok);
                            if (!ok) stop = 1'b1;
                            repeat (gap - 1) @(posedge clk);
                        end
                        if (!stop) begin
                            issue_vector(a_raw, b_raw, q_raw, f_raw);
                            n_vec++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        if (n_vec == 0) begin
            $display("no vectors were issued");
            run_errs++;
        end
        drain_results(400);
        $display("errors value %0d timing %0d run %0d, vectors %0d accepted %0d results %0d",
                 value_errs, timing_errs, run_errs, n_vec, n_acc, n_res);
        if (value_errs + timing_errs + run_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== build.f ====
src/fpdiv_pkg.sv
src/fp_unpack.sv
src/srt_quo_sel.sv
src/srt4_divider.sv
src/fp_round_pack.sv
src/fp_divider.sv
bench/fp_divider_sva.sv
bench/tb_fp_divider.sv

// ==== Makefile ====
# verilator build and run of the fp32 srt divider testbench

.PHONY: help test clean

help:
	@echo "targets"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run, check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_fp_divider -Mdir obj_dir -o tb_fp_divider
	./obj_dir/tb_fp_divider | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/fpdiv_tests.txt ====
// dividend divisor quotient flags (hex, invalid dz ovf unf inexact from msb) gap
// gap n waits for busy low plus n-1 cycles and gap 0 issues while busy
40c00000 40400000 40000000 00 1
3f800000 40000000 3f000000 00 0
3f800000 40400000 3eaaaaab 01 1
40000000 40400000 3f2aaaab 01 1
bf800000 40400000 beaaaaab 01 3
3f800000 41200000 3dcccccd 01 1
41200000 40800000 40200000 00 1
3f800000 40e00000 3e124925 01 5
3fc00000 3fa00000 3f99999a 01 1
3f800000 3f7fffff 3f800001 01 1
3f800000 3f800001 3f7ffffe 01 1
40490fdb 40000000 3fc90fdb 00 1
c0c00000 c0400000 40000000 00 1
40c00000 c0400000 c0000000 00 1
7f7fffff 3f800000 7f7fffff 00 2
7f000000 3f000000 7f800000 05 1
ff7fffff 3e800000 ff800000 05 1
00800000 3f800000 00800000 00 1
00800000 40000000 00000000 03 1
80800000 4b000000 80000000 03 1
3f800000 7f7fffff 00000000 03 1
00000000 00000000 7fc00000 10 1
7f800000 ff800000 7fc00000 10 1
ffc00000 3f800000 7fc00000 10 1
3f800000 ffc12345 7fc00000 10 1
3f800000 80000000 ff800000 08 1
c0400000 00000000 ff800000 08 1
80000000 40400000 80000000 00 1
40400000 ff800000 80000000 00 1
ff800000 40000000 ff800000 00 1
00400000 3f800000 00000000 02 1
3f800000 00000001 7f800000 0a 1
